// ==== Bender.yml ====
package:
  name: id_serialize

sources:
  - id_ser_pkg.sv
  - axi_rd_pkg.sv
  - ar_id_demux.sv
  - slot_serializer.sv
  - ar_arbiter.sv
  - r_return.sv
  - id_serialize_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_checker.sv
      - tb_id_serialize.sv

// ==== ar_arbiter.sv ====
// Round-robin AR arbiter
// Merges slot requests into one registered master AR stage tagged with the slot ID
module ar_arbiter #(
  parameter int unsigned NumSlots = 4
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic [NumSlots-1:0] slot_req_i,
  input  axi_rd_pkg::addr_t   ar_addr_i,
  input  axi_rd_pkg::len_t    ar_len_i,
  input  logic                mst_ar_ready_i,
  output logic [NumSlots-1:0] slot_grant_o,
  output logic                mst_ar_valid_o,
  output id_ser_pkg::mst_id_t mst_ar_id_o,
  output axi_rd_pkg::addr_t   mst_ar_addr_o,
  output axi_rd_pkg::len_t    mst_ar_len_o
);

  id_ser_pkg::mst_id_t rr_q;      // slot with top priority next round
  id_ser_pkg::mst_id_t pick;
  logic                pick_vld;
  logic                valid_q;
  logic                load;

  // Scan from the priority pointer, first requester wins
  always_comb begin
    int unsigned idx;
    pick     = '0;
    pick_vld = 1'b0;
    for (int unsigned i = 0; i < NumSlots; i++) begin
      idx = (32'(rr_q) + i) % NumSlots;
      if (!pick_vld && slot_req_i[idx]) begin
        pick     = id_ser_pkg::mst_id_t'(idx);
        pick_vld = 1'b1;
      end
    end
  end

  // Register free now or emptied this cycle
  assign load = pick_vld & (~valid_q | mst_ar_ready_i);

  always_comb begin
    slot_grant_o       = '0;
    slot_grant_o[pick] = load;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      rr_q    <= '0;
    end else if (load) begin
      valid_q <= 1'b1;
      // Priority moves just past the granted slot
      rr_q    <= id_ser_pkg::mst_id_t'((32'(pick) + 1) % NumSlots);
    end else if (mst_ar_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Output payload, slot index becomes the master ID
  always_ff @(posedge clk_i) begin
    if (load) begin
      mst_ar_id_o   <= pick;
      mst_ar_addr_o <= ar_addr_i;
      mst_ar_len_o  <= ar_len_i;
    end
  end

  assign mst_ar_valid_o = valid_q;

endmodule

// ==== ar_id_demux.sv ====
// AR ID demux
// Maps each slave AR ID onto a serializer slot and steers the handshake there
module ar_id_demux #(
  parameter int unsigned NumSlots     = 4,
  parameter int unsigned IdBaseOffset = 1
) (
  input  logic                slv_ar_valid_i,
  input  id_ser_pkg::slv_id_t slv_ar_id_i,
  input  logic [NumSlots-1:0] slot_ar_ready_i,
  output logic [NumSlots-1:0] slot_ar_valid_o,
  output id_ser_pkg::mst_id_t slot_sel_o,
  output logic                slv_ar_ready_o
);

  // Slot index at full integer width, before truncation
  int unsigned slot_idx;

  // Modulo map with base offset
  // Offset rotates which slot the low IDs land on
  always_comb begin
    slot_idx = (32'(slv_ar_id_i) + IdBaseOffset) % NumSlots;
  end

  // Always below NumSlots, so it fits the master ID
  assign slot_sel_o = id_ser_pkg::mst_id_t'(slot_idx);

  // Only the selected slot sees valid
  always_comb begin
    slot_ar_valid_o             = '0;
    slot_ar_valid_o[slot_sel_o] = slv_ar_valid_i;
  end

  // Ready comes back from the same slot
  // A full slot only blocks the IDs that map onto it
  assign slv_ar_ready_o = slot_ar_ready_i[slot_sel_o];

endmodule

// ==== axi_rd_pkg.sv ====
// AXI read-channel field widths and types
// Shared by the AR and R paths of both ports
package axi_rd_pkg;

  // Address width of both AR channels
  localparam int unsigned AddrWidth = 32;

  // Data width of both R channels
  localparam int unsigned DataWidth = 32;

  // Burst length field, beats minus one
  localparam int unsigned LenWidth = 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [LenWidth-1:0]  len_t;

endpackage

// ==== id_ser_pkg.sv ====
// ID widths and types for the read-path ID serializer
// Slave IDs are wide, master IDs double as the slot index
package id_ser_pkg;

  // ID width at the slave port
  localparam int unsigned SlvIdWidth = 6;

  // ID width at the master port
  localparam int unsigned MstIdWidth = 2;

  // Largest slot count the master ID can address
  // Each slot issues under its own master ID
  localparam int unsigned MaxSlots = 2 ** MstIdWidth;

  // Original transaction ID as seen at the slave port
  typedef logic [SlvIdWidth-1:0] slv_id_t;

  // Master-side ID, identical to the slot index
  typedef logic [MstIdWidth-1:0] mst_id_t;

endpackage

// ==== id_serialize_top.sv ====
// AXI read-path ID serializer
// Narrows slave AR IDs onto a few master IDs and restores them on R
module id_serialize_top #(
  parameter int unsigned NumSlots     = 4,
  parameter int unsigned TxnsPerSlot  = 2,
  parameter int unsigned IdBaseOffset = 1
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Slave AR
  input  logic                slv_ar_valid_i,
  output logic                slv_ar_ready_o,
  input  id_ser_pkg::slv_id_t slv_ar_id_i,
  input  axi_rd_pkg::addr_t   slv_ar_addr_i,
  input  axi_rd_pkg::len_t    slv_ar_len_i,
  // Slave R
  output logic                slv_r_valid_o,
  input  logic                slv_r_ready_i,
  output id_ser_pkg::slv_id_t slv_r_id_o,
  output axi_rd_pkg::data_t   slv_r_data_o,
  output logic                slv_r_last_o,
  // Master AR
  output logic                mst_ar_valid_o,
  input  logic                mst_ar_ready_i,
  output id_ser_pkg::mst_id_t mst_ar_id_o,
  output axi_rd_pkg::addr_t   mst_ar_addr_o,
  output axi_rd_pkg::len_t    mst_ar_len_o,
  // Master R
  input  logic                mst_r_valid_i,
  output logic                mst_r_ready_o,
  input  id_ser_pkg::mst_id_t mst_r_id_i,
  input  axi_rd_pkg::data_t   mst_r_data_i,
  input  logic                mst_r_last_i
);

  // Per-slot AR handshake
  logic [NumSlots-1:0] slot_ar_valid;
  logic [NumSlots-1:0] slot_ar_ready;
  logic [NumSlots-1:0] slot_req;
  logic [NumSlots-1:0] slot_grant;

  // Per-slot R return
  id_ser_pkg::slv_id_t [NumSlots-1:0] slot_r_id;
  logic [NumSlots-1:0]                slot_r_hit;
  logic                               slot_r_done;

  ar_id_demux #(
    .NumSlots     ( NumSlots     ),
    .IdBaseOffset ( IdBaseOffset )
  ) i_ar_id_demux (
    .slv_ar_valid_i  ( slv_ar_valid_i ),
    .slv_ar_id_i     ( slv_ar_id_i    ),
    .slot_ar_ready_i ( slot_ar_ready  ),
    .slot_ar_valid_o ( slot_ar_valid  ),
    // Arbiter derives the slot from the request vector
    .slot_sel_o      (                ),
    .slv_ar_ready_o  ( slv_ar_ready_o )
  );

  for (genvar i = 0; i < NumSlots; i++) begin : gen_slots
    slot_serializer #(
      .TxnsPerSlot ( TxnsPerSlot )
    ) i_slot_serializer (
      .clk_i      ( clk_i            ),
      .arst_n_i   ( arst_n_i         ),
      .ar_valid_i ( slot_ar_valid[i] ),
      .ar_id_i    ( slv_ar_id_i      ),
      .ar_grant_i ( slot_grant[i]    ),
      .ar_ready_o ( slot_ar_ready[i] ),
      .ar_req_o   ( slot_req[i]      ),
      .r_hit_i    ( slot_r_hit[i]    ),
      .r_done_i   ( slot_r_done      ),
      .r_id_o     ( slot_r_id[i]     )
    );
  end

  // Address and length go straight from the slave port to the arbiter
  ar_arbiter #(
    .NumSlots ( NumSlots )
  ) i_ar_arbiter (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .slot_req_i     ( slot_req       ),
    .ar_addr_i      ( slv_ar_addr_i  ),
    .ar_len_i       ( slv_ar_len_i   ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .slot_grant_o   ( slot_grant     ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_id_o    ( mst_ar_id_o    ),
    .mst_ar_addr_o  ( mst_ar_addr_o  ),
    .mst_ar_len_o   ( mst_ar_len_o   )
  );

  r_return #(
    .NumSlots ( NumSlots )
  ) i_r_return (
    .mst_r_valid_i ( mst_r_valid_i ),
    .mst_r_id_i    ( mst_r_id_i    ),
    .mst_r_data_i  ( mst_r_data_i  ),
    .mst_r_last_i  ( mst_r_last_i  ),
    .slv_r_ready_i ( slv_r_ready_i ),
    .slot_r_id_i   ( slot_r_id     ),
    .mst_r_ready_o ( mst_r_ready_o ),
    .slot_r_hit_o  ( slot_r_hit    ),
    .slot_r_done_o ( slot_r_done   ),
    .slv_r_valid_o ( slv_r_valid_o ),
    .slv_r_id_o    ( slv_r_id_o    ),
    .slv_r_data_o  ( slv_r_data_o  ),
    .slv_r_last_o  ( slv_r_last_o  )
  );

endmodule

// ==== r_return.sv ====
// R return router
// Sends master R beats to the slot named by their ID and restores the slave ID
module r_return #(
  parameter int unsigned NumSlots = 4
) (
  input  logic                               mst_r_valid_i,
  input  id_ser_pkg::mst_id_t                mst_r_id_i,
  input  axi_rd_pkg::data_t                  mst_r_data_i,
  input  logic                               mst_r_last_i,
  input  logic                               slv_r_ready_i,
  input  id_ser_pkg::slv_id_t [NumSlots-1:0] slot_r_id_i,
  output logic                               mst_r_ready_o,
  output logic [NumSlots-1:0]                slot_r_hit_o,
  output logic                               slot_r_done_o,
  output logic                               slv_r_valid_o,
  output id_ser_pkg::slv_id_t                slv_r_id_o,
  output axi_rd_pkg::data_t                  slv_r_data_o,
  output logic                               slv_r_last_o
);

  // One-hot slot decode of the master ID
  always_comb begin
    slot_r_hit_o = '0;
    for (int unsigned i = 0; i < NumSlots; i++) begin
      slot_r_hit_o[i] = mst_r_valid_i & (32'(mst_r_id_i) == i);
    end
  end

  // Restored ID from the head of the addressed slot
  // IDs above NumSlots never occur, they read back as zero
  always_comb begin
    slv_r_id_o = '0;
    for (int unsigned i = 0; i < NumSlots; i++) begin
      if (32'(mst_r_id_i) == i) begin
        slv_r_id_o = slot_r_id_i[i];
      end
    end
  end

  // Beat passes straight through
  assign slv_r_valid_o = mst_r_valid_i;
  assign slv_r_data_o  = mst_r_data_i;
  assign slv_r_last_o  = mst_r_last_i;
  assign mst_r_ready_o = slv_r_ready_i;

  // Last beat accepted at the slave port ends the burst
  assign slot_r_done_o = mst_r_valid_i & slv_r_ready_i & mst_r_last_i;

endmodule

// ==== sim.f ====
id_ser_pkg.sv
axi_rd_pkg.sv
ar_id_demux.sv
slot_serializer.sv
ar_arbiter.sv
r_return.sv
id_serialize_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_id_serialize.sv

// ==== slot_serializer.sv ====
// Per-slot read serializer
// Keeps the original AR IDs in issue order and restores them on R beats
module slot_serializer #(
  parameter int unsigned TxnsPerSlot = 2
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // AR side
  input  logic                ar_valid_i,
  input  id_ser_pkg::slv_id_t ar_id_i,
  input  logic                ar_grant_i,
  output logic                ar_ready_o,
  output logic                ar_req_o,
  // R side
  input  logic                r_hit_i,
  input  logic                r_done_i,
  output id_ser_pkg::slv_id_t r_id_o
);

  localparam int unsigned PtrWidth = (TxnsPerSlot > 1) ? $clog2(TxnsPerSlot) : 1;
  localparam int unsigned CntWidth = $clog2(TxnsPerSlot + 1);

  // Original IDs, oldest at the read pointer
  id_ser_pkg::slv_id_t id_mem [TxnsPerSlot];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;
  logic                full;
  logic                push;
  logic                pop;

  // Pointer step with wrap at the FIFO depth
  // Depth need not be a power of two
  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(TxnsPerSlot - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full = (cnt_q == CntWidth'(TxnsPerSlot));

  // Ask the arbiter only while an ID slot is free
  assign ar_req_o = ar_valid_i & ~full;

  // Grant implies a request, so it already includes room
  assign ar_ready_o = ar_grant_i;

  // AR transfer of this slot
  assign push = ar_valid_i & ar_grant_i;

  // Last beat addressed to this slot retires the head
  assign pop = r_hit_i & r_done_i & (cnt_q != '0);

  // All reads of the slot share one master ID
  // Responses therefore come back in issue order, head is the match
  assign r_id_o = id_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Fill count, unchanged on push and pop together
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // ID storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      id_mem[wr_ptr_q] <= ar_id_i;
    end
  end

endmodule

// ==== tb_checker.sv ====
// Read-path checker
// Watches both DUT ports and compares against the ID map and ordering rules
module tb_checker (
  input logic                clk_i,
  input logic                arst_n_i,
  input logic                slv_ar_valid_i,
  input logic                slv_ar_ready_i,
  input id_ser_pkg::slv_id_t slv_ar_id_i,
  input axi_rd_pkg::addr_t   slv_ar_addr_i,
  input axi_rd_pkg::len_t    slv_ar_len_i,
  input logic                slv_r_valid_i,
  input logic                slv_r_ready_i,
  input id_ser_pkg::slv_id_t slv_r_id_i,
  input axi_rd_pkg::data_t   slv_r_data_i,
  input logic                slv_r_last_i,
  input logic                mst_ar_valid_i,
  input logic                mst_ar_ready_i,
  input id_ser_pkg::mst_id_t mst_ar_id_i,
  input axi_rd_pkg::addr_t   mst_ar_addr_i,
  input axi_rd_pkg::len_t    mst_ar_len_i,
  input id_ser_pkg::mst_id_t mst_r_id_i
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumSlots  = 4;
  localparam int unsigned IdOffset  = 1;
  // Slot that receives the stalled burst of reads
  localparam int          WatchSlot = 2;
  localparam int          SlotDepth = 2;

  typedef struct packed {
    id_ser_pkg::slv_id_t id;
    axi_rd_pkg::addr_t   addr;
    axi_rd_pkg::len_t    len;
  } rd_t;

  // Slave ARs not yet seen at the master port
  rd_t         ar_q[$];
  // Reads still owing R beats, oldest first
  rd_t         rsp_q[$];
  int unsigned beat_cnt [64] = '{default: 0};
  int          watch_out    = 0;
  int unsigned mismatch_cnt = 0;
  int unsigned other_cnt    = 0;
  int unsigned last_cnt     = 0;

  // Slot an ID lands on, (id + offset) mod slots
  function automatic id_ser_pkg::mst_id_t slot_of(input id_ser_pkg::slv_id_t id);
    return id_ser_pkg::mst_id_t'((32'(id) + IdOffset) % NumSlots);
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  // Both valids low on the first edge after reset
  initial begin : reset_check
    int unsigned waited;
    waited = 0;
    while (arst_n_i !== 1'b1 && waited < 50) begin
      @(posedge clk_i);
      waited++;
    end
    if (arst_n_i !== 1'b1) begin
      $display("Reset was never released");
      other_cnt++;
    end else begin
      @(posedge clk_i);
      compare("mst_ar_valid_o", mst_ar_valid_i, 1'b0);
      compare("slv_r_valid_o", slv_r_valid_i, 1'b0);
    end
  end

  always @(posedge clk_i) begin : monitor
    rd_t cur;
    int  idx;
    if (arst_n_i === 1'b1) begin
      // R beat goes to the oldest open read of its slave ID
      if (slv_r_valid_i && slv_r_ready_i) begin
        compare("slv_r_id_o slot", slot_of(slv_r_id_i), mst_r_id_i);
        idx = -1;
        for (int i = rsp_q.size() - 1; i >= 0; i--) begin
          if (rsp_q[i].id == slv_r_id_i) begin
            idx = i;
          end
        end
        if (idx < 0) begin
          $display("R beat for slave ID 0x%0h with no read outstanding", slv_r_id_i);
          other_cnt++;
        end else begin
          cur = rsp_q[idx];
          compare("slv_r_data_o", slv_r_data_i,
                  axi_rd_pkg::data_t'(cur.addr + beat_cnt[cur.id]));
          compare("slv_r_last_o", slv_r_last_i, beat_cnt[cur.id] == 32'(cur.len));
          if (slv_r_last_i) begin
            rsp_q.delete(idx);
            beat_cnt[cur.id] = 0;
          end else begin
            beat_cnt[cur.id]++;
          end
        end
        // Every last beat at the slave port counts, matched or not
        if (slv_r_last_i) begin
          last_cnt++;
        end
        if (slv_r_last_i && mst_r_id_i == WatchSlot) begin
          watch_out--;
        end
      end
      // Master AR follows slave AR order with the mapped ID
      if (mst_ar_valid_i && mst_ar_ready_i) begin
        if (ar_q.size() == 0) begin
          $display("Master AR issued with no slave AR pending");
          other_cnt++;
        end else begin
          cur = ar_q.pop_front();
          compare("mst_ar_id_o", mst_ar_id_i, slot_of(cur.id));
          compare("mst_ar_addr_o", mst_ar_addr_i, cur.addr);
          compare("mst_ar_len_o", mst_ar_len_i, cur.len);
        end
        if (mst_ar_id_i == WatchSlot) begin
          watch_out++;
          if (watch_out > SlotDepth) begin
            $display("Slot %0d has %0d reads outstanding at the master, limit %0d",
                     WatchSlot, watch_out, SlotDepth);
            other_cnt++;
          end
        end
      end
      // Accepted slave AR opens a read
      if (slv_ar_valid_i && slv_ar_ready_i) begin
        cur.id   = slv_ar_id_i;
        cur.addr = slv_ar_addr_i;
        cur.len  = slv_ar_len_i;
        ar_q.push_back(cur);
        rsp_q.push_back(cur);
      end
    end
  end

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and reset
// 10 ns clock, reset held low for the first 4 cycles
module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned HalfPeriod  = 5;
  localparam int unsigned ResetCycles = 4;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HalfPeriod) clk_o = ~clk_o;
    end
  end

  // Release just after an edge so no flop sees it change on the edge
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule

// ==== tb_id_serialize.sv ====
// Testbench top for the read-path ID serializer
// Applies a table of reads and models the master-side memory
module tb_id_serialize;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumReads    = 14;
  localparam int unsigned WaitLimit   = 400;
  localparam int unsigned DrainLimit  = 3000;
  localparam int unsigned StallCycles = 40;

  // Stall holds back memory responses while the row is driven
  typedef struct packed {
    logic                stall;
    id_ser_pkg::slv_id_t id;
    axi_rd_pkg::addr_t   addr;
    axi_rd_pkg::len_t    len;
  } read_t;

  typedef struct packed {
    id_ser_pkg::mst_id_t id;
    axi_rd_pkg::addr_t   addr;
    axi_rd_pkg::len_t    len;
  } burst_t;

  logic                clk_i;
  logic                arst_n_i;
  logic                slv_ar_valid_i = 1'b0;
  logic                slv_ar_ready_o;
  id_ser_pkg::slv_id_t slv_ar_id_i    = '0;
  axi_rd_pkg::addr_t   slv_ar_addr_i  = '0;
  axi_rd_pkg::len_t    slv_ar_len_i   = '0;
  logic                slv_r_valid_o;
  logic                slv_r_ready_i  = 1'b0;
  id_ser_pkg::slv_id_t slv_r_id_o;
  axi_rd_pkg::data_t   slv_r_data_o;
  logic                slv_r_last_o;
  logic                mst_ar_valid_o;
  logic                mst_ar_ready_i = 1'b0;
  id_ser_pkg::mst_id_t mst_ar_id_o;
  axi_rd_pkg::addr_t   mst_ar_addr_o;
  axi_rd_pkg::len_t    mst_ar_len_o;
  logic                mst_r_valid_i  = 1'b0;
  logic                mst_r_ready_o;
  id_ser_pkg::mst_id_t mst_r_id_i     = '0;
  axi_rd_pkg::data_t   mst_r_data_i   = '0;
  logic                mst_r_last_i   = 1'b0;

  read_t       reads [NumReads];
  burst_t      mem_q[$];
  integer      seed          = 25745;
  int unsigned beat          = 0;
  int unsigned cyc           = 0;
  int unsigned stall_until   = 0;
  logic        stall_req     = 1'b0;
  int unsigned timeout_cnt   = 0;
  int unsigned drain_err_cnt = 0;

  tb_clk_gen i_clk_gen (
    .clk_o    ( clk_i    ),
    .arst_n_o ( arst_n_i )
  );

  id_serialize_top #(
    .NumSlots     ( 4 ),
    .TxnsPerSlot  ( 2 ),
    .IdBaseOffset ( 1 )
  ) i_id_serialize_top (.*);

  tb_checker i_checker (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_i ( slv_ar_ready_o ),
    .slv_ar_id_i    ( slv_ar_id_i    ),
    .slv_ar_addr_i  ( slv_ar_addr_i  ),
    .slv_ar_len_i   ( slv_ar_len_i   ),
    .slv_r_valid_i  ( slv_r_valid_o  ),
    .slv_r_ready_i  ( slv_r_ready_i  ),
    .slv_r_id_i     ( slv_r_id_o     ),
    .slv_r_data_i   ( slv_r_data_o   ),
    .slv_r_last_i   ( slv_r_last_o   ),
    .mst_ar_valid_i ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_ar_id_i    ( mst_ar_id_o    ),
    .mst_ar_addr_i  ( mst_ar_addr_o  ),
    .mst_ar_len_i   ( mst_ar_len_o   ),
    .mst_r_id_i     ( mst_r_id_i     )
  );

  // Master-side memory, answers in acceptance order
  // Beat data is the burst address plus the beat number
  always begin : memory_model
    burst_t acc;
    logic   r_hold;
    @(posedge clk_i);
    cyc++;
    if (stall_req) begin
      stall_until = cyc + StallCycles;
    end
    if (mst_ar_valid_o && mst_ar_ready_i) begin
      acc.id   = mst_ar_id_o;
      acc.addr = mst_ar_addr_o;
      acc.len  = mst_ar_len_o;
      mem_q.push_back(acc);
    end
    r_hold = mst_r_valid_i && !mst_r_ready_o;
    if (mst_r_valid_i && mst_r_ready_o) begin
      if (mst_r_last_i) begin
        void'(mem_q.pop_front());
        beat = 0;
      end else begin
        beat++;
      end
    end
    #1;
    mst_ar_ready_i = (arst_n_i === 1'b1) && (($random(seed) & 3) != 0);
    slv_r_ready_i  = (arst_n_i === 1'b1) && (($random(seed) & 3) != 0);
    // Valid holds once raised, a started burst runs through a stall
    if (mem_q.size() != 0 && (r_hold || beat != 0 || cyc >= stall_until)) begin
      mst_r_valid_i = 1'b1;
      mst_r_id_i    = mem_q[0].id;
      mst_r_data_i  = axi_rd_pkg::data_t'(mem_q[0].addr + beat);
      mst_r_last_i  = (beat == 32'(mem_q[0].len));
    end else begin
      mst_r_valid_i = 1'b0;
      mst_r_last_i  = 1'b0;
    end
  end

  // Rows 3 to 7 all map to slot 2 while responses stall
  // ID 0x3E three times overfills slot 3
  task automatic fill_reads();
    reads[0]  = '{1'b0, 6'h00, 32'h0000_1000, 8'd0};
    reads[1]  = '{1'b0, 6'h03, 32'h0000_2000, 8'd3};
    reads[2]  = '{1'b0, 6'h2A, 32'h0000_3000, 8'd1};
    reads[3]  = '{1'b1, 6'h01, 32'h0000_4000, 8'd2};
    reads[4]  = '{1'b0, 6'h05, 32'h0000_4100, 8'd0};
    reads[5]  = '{1'b0, 6'h09, 32'h0000_4200, 8'd1};
    reads[6]  = '{1'b0, 6'h0D, 32'h0000_4300, 8'd3};
    reads[7]  = '{1'b0, 6'h11, 32'h0000_4400, 8'd0};
    reads[8]  = '{1'b0, 6'h3F, 32'h0000_5000, 8'd2};
    reads[9]  = '{1'b0, 6'h3E, 32'h0000_6000, 8'd1};
    reads[10] = '{1'b0, 6'h3E, 32'h0000_6100, 8'd0};
    reads[11] = '{1'b0, 6'h3E, 32'h0000_6200, 8'd4};
    reads[12] = '{1'b0, 6'h22, 32'h0000_7000, 8'd7};
    reads[13] = '{1'b0, 6'h00, 32'h0000_8000, 8'd1};
  endtask

  // Back-to-back slave ARs, each held until accepted
  task automatic send_reads();
    int unsigned waited;
    logic        done;
    for (int unsigned i = 0; i < NumReads; i++) begin
      slv_ar_valid_i = 1'b1;
      slv_ar_id_i    = reads[i].id;
      slv_ar_addr_i  = reads[i].addr;
      slv_ar_len_i   = reads[i].len;
      stall_req      = reads[i].stall;
      waited = 0;
      done   = 1'b0;
      while (!done && waited < WaitLimit) begin
        @(posedge clk_i);
        done = slv_ar_ready_o;
        waited++;
      end
      #1;
      if (!done) begin
        $display("Timeout: read %0d with ID 0x%0h was not accepted", i, reads[i].id);
        timeout_cnt++;
        break;
      end
    end
    slv_ar_valid_i = 1'b0;
    stall_req      = 1'b0;
  endtask

  task automatic drain();
    int unsigned waited;
    waited = 0;
    while (i_checker.last_cnt < NumReads && waited < DrainLimit) begin
      @(posedge clk_i);
      waited++;
    end
    if (i_checker.last_cnt < NumReads) begin
      $display("Timeout: %0d of %0d reads completed", i_checker.last_cnt, NumReads);
      timeout_cnt++;
    end else begin
      // Quiet period exposes duplicated beats
      repeat (20) @(posedge clk_i);
      if (i_checker.last_cnt != NumReads) begin
        $display("Saw %0d last beats for %0d reads", i_checker.last_cnt, NumReads);
        drain_err_cnt++;
      end
    end
  endtask

  task automatic finish_run();
    int unsigned other;
    other = i_checker.other_cnt + drain_err_cnt;
    $display("Error counts: mismatch %0d, other %0d, timeout %0d",
             i_checker.mismatch_cnt, other, timeout_cnt);
    if (i_checker.mismatch_cnt == 0 && other == 0 && timeout_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  initial begin : stimulus
    int unsigned waited;
    fill_reads();
    waited = 0;
    while (arst_n_i !== 1'b1 && waited < WaitLimit) begin
      @(posedge clk_i);
      waited++;
    end
    if (arst_n_i !== 1'b1) begin
      $display("Timeout: reset was never released");
      timeout_cnt++;
    end else begin
      // Leave one edge for the idle check after reset
      repeat (2) @(posedge clk_i);
      #1;
      send_reads();
      if (timeout_cnt == 0) begin
        drain();
      end
    end
    finish_run();
  end

endmodule
